// File: hdl/exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// Execute lane sizing

// Operand and result width
`define EXE_DATA_W 32

// Physical register tag width, tag 0 is the zero register
`define EXE_TAG_W 6

// Active list id width, one id per in-flight instruction
`define EXE_ALID_W 5

// Registered stages inside the complex unit
// Complex latency is this plus the writeback register
`define EXE_CPLX_DEPTH 3

`endif

// File: hdl/exePkg.sv
`include "exe_config.svh"

package exePkg;

  // One data word as read from the register file
  typedef logic [`EXE_DATA_W-1:0]   dataT;

  // Full product of two data words
  typedef logic [2*`EXE_DATA_W-1:0] prodT;

  // Physical register tag
  typedef logic [`EXE_TAG_W-1:0]    phyRegT;

  // Active list id, used to retire out of order results
  typedef logic [`EXE_ALID_W-1:0]   alIdT;

  // Shift amount, low bits of src2
  typedef logic [$clog2(`EXE_DATA_W)-1:0] shamtT;

  // Opcode space of the lane
  // Bit 3 set marks the complex unit
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLT   = 4'd5,   // Signed compare
    OP_SLL   = 4'd6,
    OP_SRL   = 4'd7,   // Logical, zero fill
    OP_MUL   = 4'd8,   // Low half of product
    OP_MULHU = 4'd9,   // High half, both unsigned
    OP_DIVU  = 4'd10   // Unsigned quotient
  } opcodeT;

endpackage

// File: hdl/exeIf.sv
`timescale 1ns/1ps

// Issue to a functional unit, one cycle pulse per instruction
interface issueIf;
  import exePkg::*;

  logic   valid;
  opcodeT opcode;
  dataT   src1;     // Already forwarded
  dataT   src2;
  phyRegT dest;
  alIdT   alId;

  modport send (output valid, opcode, src1, src2, dest, alId);
  modport take (input  valid, opcode, src1, src2, dest, alId);
endinterface

// Result from a functional unit toward writeback
interface resultIf;
  import exePkg::*;

  logic   valid;
  phyRegT dest;
  alIdT   alId;
  dataT   data;
  logic   exception;  // Overflow or divide by zero

  modport send (output valid, dest, alId, data, exception);
  modport take (input  valid, dest, alId, data, exception);
endinterface

// File: hdl/OperandSelect.sv
`timescale 1ns/1ps

module OperandSelect (
  input  logic           exeValid_i,
  input  exePkg::opcodeT exeOpcode_i,
  input  exePkg::phyRegT phySrc1_i,
  input  exePkg::dataT   src1Data_i,
  input  exePkg::phyRegT phySrc2_i,
  input  exePkg::dataT   src2Data_i,
  input  exePkg::phyRegT phyDest_i,
  input  exePkg::alIdT   alId_i,
  input  logic           recoverFlag_i,
  input  logic           extBypValid_i,
  input  exePkg::phyRegT extBypReg_i,
  input  exePkg::dataT   extBypData_i,
  input  logic           wbValid_i,   // Lane's own writeback, fed back
  input  exePkg::phyRegT wbDest_i,
  input  exePkg::dataT   wbData_i,
  issueIf.send           simpleIss,
  issueIf.send           complexIss
);
  import exePkg::*;

  dataT src1Fwd;
  dataT src2Fwd;
  logic isCplx;

  // Pick the newest value for one source
  // External pipe is checked first, it holds the younger result
  function automatic dataT fwdSrc (
    input phyRegT tag,
    input dataT   regData,
    input logic   extValid,
    input phyRegT extTag,
    input dataT   extData,
    input logic   ownValid,
    input phyRegT ownTag,
    input dataT   ownData
  );
    dataT val;
    val = regData;                              // Register read value by default
    if (tag != '0 && ownValid && tag == ownTag)
      val = ownData;
    if (tag != '0 && extValid && tag == extTag) // Overrides own writeback
      val = extData;
    return val;
  endfunction

  always_comb
  begin
    src1Fwd = fwdSrc(phySrc1_i, src1Data_i, extBypValid_i, extBypReg_i, extBypData_i,
                     wbValid_i, wbDest_i, wbData_i);
    src2Fwd = fwdSrc(phySrc2_i, src2Data_i, extBypValid_i, extBypReg_i, extBypData_i,
                     wbValid_i, wbDest_i, wbData_i);
  end

  assign isCplx = exeOpcode_i[3];   // Upper half of opcode space

  // Payload goes to both units, only one valid rises
  assign simpleIss.valid   = exeValid_i && !isCplx && !recoverFlag_i;
  assign simpleIss.opcode  = exeOpcode_i;
  assign simpleIss.src1    = src1Fwd;
  assign simpleIss.src2    = src2Fwd;
  assign simpleIss.dest    = phyDest_i;
  assign simpleIss.alId    = alId_i;

  assign complexIss.valid  = exeValid_i && isCplx && !recoverFlag_i;
  assign complexIss.opcode = exeOpcode_i;
  assign complexIss.src1   = src1Fwd;
  assign complexIss.src2   = src2Fwd;
  assign complexIss.dest   = phyDest_i;
  assign complexIss.alId   = alId_i;

  // Issue queue must never send an undefined opcode
  always_comb
  begin
    if (exeValid_i)
      illegalOp: assert final (exeOpcode_i <= OP_DIVU)
        else $error("Illegal opcode %0h issued", exeOpcode_i);
  end

endmodule

// File: hdl/SimpleAlu.sv
`timescale 1ns/1ps

module SimpleAlu (
  issueIf.take  iss,
  resultIf.send res
);
  import exePkg::*;

  dataT  result;
  dataT  sum;
  dataT  diff;
  shamtT shamt;
  logic  addOvf;
  logic  subOvf;
  logic  ovf;

  assign sum   = iss.src1 + iss.src2;
  assign diff  = iss.src1 - iss.src2;
  assign shamt = iss.src2[$bits(shamtT)-1:0];   // Low bits only

  // Same sign in, other sign out
  assign addOvf = (iss.src1[$bits(dataT)-1] == iss.src2[$bits(dataT)-1]) &&
                  (sum[$bits(dataT)-1] != iss.src1[$bits(dataT)-1]);
  // Signs differ and result takes the subtrahend's sign
  assign subOvf = (iss.src1[$bits(dataT)-1] != iss.src2[$bits(dataT)-1]) &&
                  (diff[$bits(dataT)-1] != iss.src1[$bits(dataT)-1]);

  always_comb
  begin
    result = '0;
    ovf    = 1'b0;
    case (iss.opcode)
      OP_ADD:
      begin
        result = sum;
        ovf    = addOvf;
      end
      OP_SUB:
      begin
        result = diff;
        ovf    = subOvf;
      end
      OP_AND:  result = iss.src1 & iss.src2;
      OP_OR:   result = iss.src1 | iss.src2;
      OP_XOR:  result = iss.src1 ^ iss.src2;
      OP_SLT:  result = dataT'($signed(iss.src1) < $signed(iss.src2));
      OP_SLL:  result = iss.src1 << shamt;
      OP_SRL:  result = iss.src1 >> shamt;
      default: result = '0;   // Complex opcodes never valid here
    endcase
  end

  assign res.valid     = iss.valid;
  assign res.dest      = iss.dest;
  assign res.alId      = iss.alId;
  assign res.data      = result;
  assign res.exception = ovf;

endmodule

// File: hdl/ComplexAlu.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module ComplexAlu (
  input  logic  clk_i,
  input  logic  arstN_i,
  input  logic  recoverFlag_i,
  issueIf.take  iss,
  resultIf.send res
);
  import exePkg::*;

  localparam int DEPTH = `EXE_CPLX_DEPTH;

  prodT   prod;
  logic   divZero;
  dataT   cplxData;
  logic   cplxExc;

  // Pipeline state, only valid bits are reset
  logic [DEPTH-1:0] stgValid;
  logic [DEPTH-1:0] stgExc;
  dataT             stgData [DEPTH];
  phyRegT           stgDest [DEPTH];
  alIdT             stgAlId [DEPTH];

  // Full unsigned product, both halves used
  assign prod    = prodT'(iss.src1) * prodT'(iss.src2);
  assign divZero = (iss.src2 == '0);

  always_comb
  begin
    cplxData = '0;
    cplxExc  = 1'b0;
    case (iss.opcode)
      OP_MUL:   cplxData = prod[$bits(dataT)-1:0];
      OP_MULHU: cplxData = prod[$bits(prodT)-1:$bits(dataT)];
      OP_DIVU:
      begin
        if (divZero)
        begin
          cplxData = '1;          // All ones quotient
          cplxExc  = 1'b1;
        end
        else
        begin
          cplxData = iss.src1 / iss.src2;
        end
      end
      default: cplxData = '0;     // Simple opcodes never valid here
    endcase
  end

  // Valid shift register, flushed as a whole on recovery
  always_ff @(posedge clk_i or negedge arstN_i)
  begin
    if (!arstN_i)
    begin
      stgValid <= '0;
    end
    else if (recoverFlag_i)
    begin
      stgValid <= '0;             // Drops entry and every stage
    end
    else
    begin
      stgValid[0] <= iss.valid;
      for (int i = 1; i < DEPTH; i++)
        stgValid[i] <= stgValid[i-1];
    end
  end

  // Payload follows its valid bit
  always_ff @(posedge clk_i)
  begin
    stgData[0] <= cplxData;
    stgExc[0]  <= cplxExc;
    stgDest[0] <= iss.dest;
    stgAlId[0] <= iss.alId;
    for (int i = 1; i < DEPTH; i++)
    begin
      stgData[i] <= stgData[i-1];
      stgExc[i]  <= stgExc[i-1];
      stgDest[i] <= stgDest[i-1];
      stgAlId[i] <= stgAlId[i-1];
    end
  end

  assign res.valid     = stgValid[DEPTH-1];   // Last stage feeds writeback
  assign res.dest      = stgDest[DEPTH-1];
  assign res.alId      = stgAlId[DEPTH-1];
  assign res.data      = stgData[DEPTH-1];
  assign res.exception = stgExc[DEPTH-1];

endmodule

// File: hdl/WritebackSelect.sv
`timescale 1ns/1ps

module WritebackSelect (
  input  logic           clk_i,
  input  logic           arstN_i,
  input  logic           recoverFlag_i,
  resultIf.take          simpleRes,
  resultIf.take          complexRes,
  output logic           wbValid_o,
  output exePkg::phyRegT wbDest_o,
  output exePkg::alIdT   wbAlId_o,
  output exePkg::dataT   wbData_o,
  output logic           wbException_o
);
  import exePkg::*;

  // Writeback valid, cleared by reset and flush
  always_ff @(posedge clk_i or negedge arstN_i)
  begin
    if (!arstN_i)
      wbValid_o <= 1'b0;
    else if (recoverFlag_i)
      wbValid_o <= 1'b0;
    else
      wbValid_o <= simpleRes.valid || complexRes.valid;
  end

  // Packet payload, simple wins only when complex is idle
  always_ff @(posedge clk_i)
  begin
    if (complexRes.valid)
    begin
      wbDest_o      <= complexRes.dest;
      wbAlId_o      <= complexRes.alId;
      wbData_o      <= complexRes.data;
      wbException_o <= complexRes.exception;
    end
    else if (simpleRes.valid)
    begin
      wbDest_o      <= simpleRes.dest;
      wbAlId_o      <= simpleRes.alId;
      wbData_o      <= simpleRes.data;
      wbException_o <= simpleRes.exception;
    end
  end

  // Single writeback port, issue must keep the units apart
  wbCollision: assert property (
    @(posedge clk_i) disable iff (!arstN_i)
    !(simpleRes.valid && complexRes.valid)
  ) else $error("Simple and complex results collide at writeback");

endmodule

// File: hdl/ExecuteLane.sv
`timescale 1ns/1ps

module ExecuteLane (
  input  logic           clk_i,
  input  logic           arstN_i,
  input  logic           recoverFlag_i,

  input  logic           exeValid_i,       // Issued instruction
  input  exePkg::opcodeT exeOpcode_i,
  input  exePkg::phyRegT phySrc1_i,
  input  exePkg::dataT   src1Data_i,
  input  exePkg::phyRegT phySrc2_i,
  input  exePkg::dataT   src2Data_i,
  input  exePkg::phyRegT phyDest_i,
  input  exePkg::alIdT   alId_i,

  input  logic           extBypValid_i,    // Other pipe's bypass
  input  exePkg::phyRegT extBypReg_i,
  input  exePkg::dataT   extBypData_i,

  output logic           wbValid_o,        // Also this lane's bypass
  output exePkg::phyRegT wbDest_o,
  output exePkg::alIdT   wbAlId_o,
  output exePkg::dataT   wbData_o,
  output logic           wbException_o
);

  issueIf  simpleIss ();
  issueIf  complexIss ();
  resultIf simpleRes ();
  resultIf complexRes ();

  OperandSelect operandSel (
    .exeValid_i    (exeValid_i),
    .exeOpcode_i   (exeOpcode_i),
    .phySrc1_i     (phySrc1_i),
    .src1Data_i    (src1Data_i),
    .phySrc2_i     (phySrc2_i),
    .src2Data_i    (src2Data_i),
    .phyDest_i     (phyDest_i),
    .alId_i        (alId_i),
    .recoverFlag_i (recoverFlag_i),
    .extBypValid_i (extBypValid_i),
    .extBypReg_i   (extBypReg_i),
    .extBypData_i  (extBypData_i),
    .wbValid_i     (wbValid_o),      // Own writeback loops back
    .wbDest_i      (wbDest_o),
    .wbData_i      (wbData_o),
    .simpleIss     (simpleIss.send),
    .complexIss    (complexIss.send)
  );

  SimpleAlu simpleAlu (
    .iss (simpleIss.take),
    .res (simpleRes.send)
  );

  ComplexAlu complexAlu (
    .clk_i         (clk_i),
    .arstN_i       (arstN_i),
    .recoverFlag_i (recoverFlag_i),
    .iss           (complexIss.take),
    .res           (complexRes.send)
  );

  WritebackSelect wbSel (
    .clk_i         (clk_i),
    .arstN_i       (arstN_i),
    .recoverFlag_i (recoverFlag_i),
    .simpleRes     (simpleRes.take),
    .complexRes    (complexRes.take),
    .wbValid_o     (wbValid_o),
    .wbDest_o      (wbDest_o),
    .wbAlId_o      (wbAlId_o),
    .wbData_o      (wbData_o),
    .wbException_o (wbException_o)
  );

endmodule

// File: verif/ClockGen.sv
`timescale 1ns/1ps

// Free running 10 ns clock and a reset held low for four cycles
module ClockGen (
  output logic clk_o,
  output logic arstN_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;   // 100 MHz
  end

  initial
  begin
    arstN_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);            // Release away from the sampling edge
    arstN_o = 1'b1;
  end

endmodule

// File: verif/ExecuteLane_tb.sv
`timescale 1ns/1ps
`include "exe_config.svh"

module ExecuteLane_tb;
  import exePkg::*;

  localparam int FIELDS    = 15;    // Words per test line
  localparam int MAX_TESTS = 64;
  localparam int IDS       = 1 << `EXE_ALID_W;

  logic   clk_i;
  logic   arstN_i;
  logic   recoverFlag_i;
  logic   exeValid_i;
  opcodeT exeOpcode_i;
  phyRegT phySrc1_i;
  dataT   src1Data_i;
  phyRegT phySrc2_i;
  dataT   src2Data_i;
  phyRegT phyDest_i;
  alIdT   alId_i;
  logic   extBypValid_i;
  phyRegT extBypReg_i;
  dataT   extBypData_i;
  logic   wbValid_o;
  phyRegT wbDest_o;
  alIdT   wbAlId_o;
  dataT   wbData_o;
  logic   wbException_o;

  logic [31:0] testMem [FIELDS*MAX_TESTS];
  logic [31:0] lfsrState;
  int          numTests;
  logic        loaded;
  longint      edgeCnt = 0;
  longint      lastCplxEdge = -100;   // Sampling edge of newest complex op

  // Scoreboard indexed by active list id
  logic   expPending [IDS];
  logic   expCancel  [IDS];
  dataT   expData    [IDS];
  phyRegT expDest    [IDS];
  logic   expExc     [IDS];
  alIdT   wbOrder    [$];   // Drained issue keeps writeback in issue order

  ClockGen clkGen (.clk_o(clk_i), .arstN_o(arstN_i));

  ExecuteLane ExecuteLane_i (.*);

  task automatic abortRun();
    $display(">>> FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkData(input string name, input dataT got, input dataT exp);
    if (got !== exp)
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkTag(input string name, input phyRegT got, input phyRegT exp);
    if (got !== exp)
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkAlId(input string name, input alIdT got, input alIdT exp);
    if (got !== exp)
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abortRun();
    end
  endtask

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  // Two LFSR bits give 0 to 3 idle cycles
  function automatic int pickIdleCycles();
    int n;
    n = 0;
    for (int b = 0; b < 2; b++)
    begin
      n = n | (int'(lfsrState[0]) << b);
      lfsrState = nextLfsr(lfsrState);
    end
    return n;
  endfunction

  task automatic driveIdle();
    recoverFlag_i = 1'b0;
    exeValid_i    = 1'b0;
    exeOpcode_i   = OP_ADD;
    phySrc1_i     = '0;
    src1Data_i    = '0;
    phySrc2_i     = '0;
    src2Data_i    = '0;
    phyDest_i     = '0;
    alId_i        = '0;
    extBypValid_i = 1'b0;
    extBypReg_i   = '0;
    extBypData_i  = '0;
  endtask

  // Drive one test line for a single cycle and log what it should produce
  task automatic issueLine(input int k);
    int   b;
    alIdT id;
    b  = k * FIELDS;
    id = alIdT'(testMem[b+6]);
    exeValid_i    = 1'b1;
    exeOpcode_i   = opcodeT'(testMem[b][3:0]);
    phySrc1_i     = phyRegT'(testMem[b+1]);
    src1Data_i    = testMem[b+2];
    phySrc2_i     = phyRegT'(testMem[b+3]);
    src2Data_i    = testMem[b+4];
    phyDest_i     = phyRegT'(testMem[b+5]);
    alId_i        = id;
    extBypValid_i = testMem[b+7][0];
    extBypReg_i   = phyRegT'(testMem[b+8]);
    extBypData_i  = testMem[b+9];
    recoverFlag_i = testMem[b+10][0];
    if (testMem[b+12][0])
      expCancel[id] = 1'b1;           // Flushed before it reaches writeback
    else
    begin
      expPending[id] = 1'b1;
      expData[id]    = testMem[b+13];
      expDest[id]    = phyDest_i;
      expExc[id]     = testMem[b+14][0];
      wbOrder.push_back(id);
    end
    if (exeOpcode_i[3])
      lastCplxEdge = edgeCnt + 1;
    @(negedge clk_i);
    driveIdle();
  endtask

  always @(posedge clk_i)
    edgeCnt <= edgeCnt + 1;

  // Writeback is registered, so mid cycle it is settled
  always @(negedge clk_i)
  begin : wbMonitor
    alIdT id;
    if (wbValid_o === 1'b1)
    begin
      id = wbAlId_o;
      if (expCancel[id])
      begin
        $display("Writeback appeared for cancelled id %0d", id);
        abortRun();
      end
      else if (expPending[id] !== 1'b1)
      begin
        $display("Writeback appeared for id %0d with nothing outstanding", id);
        abortRun();
      end
      else
      begin
        checkAlId("wbAlId_o", wbAlId_o, wbOrder.pop_front());
        checkTag("wbDest_o", wbDest_o, expDest[id]);
        checkData("wbData_o", wbData_o, expData[id]);
        checkFlag("wbException_o", wbException_o, expExc[id]);
        expPending[id] = 1'b0;
      end
    end
    else if (wbValid_o !== 1'b0 && arstN_i === 1'b1)
    begin
      $display("wbValid_o is unknown after reset");
      abortRun();
    end
  end

  initial
  begin : stimulus
    int   idle;
    logic missing;
    loaded    = 1'b0;
    lfsrState = 32'h0642_200a;
    driveIdle();
    for (int i = 0; i < IDS; i++)
    begin
      expPending[i] = 1'b0;
      expCancel[i]  = 1'b0;
    end
    for (int i = 0; i < FIELDS*MAX_TESTS; i++)
      testMem[i] = '1;                // All ones opcode word ends the list
    $readmemh("verif/execute_tests.txt", testMem);
    numTests = 0;
    while (numTests < MAX_TESTS && testMem[numTests*FIELDS] !== 32'hFFFF_FFFF)
      numTests++;
    loaded = 1'b1;
    @(posedge arstN_i);
    repeat (3) @(negedge clk_i);      // Monitor flags any writeback here
    for (int k = 0; k < numTests; k++)
    begin
      if (!testMem[k*FIELDS+11][0])
      begin
        idle = pickIdleCycles();
        repeat (idle) @(negedge clk_i);
      end
      // Simple result must not land on the edge a complex one does
      if (!testMem[k*FIELDS][3])
      begin
        while (edgeCnt + 1 <= lastCplxEdge + `EXE_CPLX_DEPTH)
          @(negedge clk_i);
      end
      issueLine(k);
    end
    repeat (`EXE_CPLX_DEPTH + 3) @(negedge clk_i);
    missing = 1'b0;
    for (int i = 0; i < IDS; i++)
    begin
      if (expPending[i])
      begin
        $display("Expected writeback for id %0d never arrived", i);
        missing = 1'b1;
      end
    end
    if (missing)
      abortRun();
    else
    begin
      $display(">>> PASS");
      $finish;
    end
  end

  initial
  begin : watchdog
    wait (loaded === 1'b1);
    if (numTests == 0)
      $display("No test lines read from verif/execute_tests.txt");
    else
    begin
      #(numTests * (`EXE_CPLX_DEPTH + 8) * 10 + 40);
      $display("Timeout with %0d writebacks outstanding", wbOrder.size());
    end
    abortRun();
  end

endmodule

// File: verif/execute_tests.txt
// op t1 d1 t2 d2 dest alId extV extT extD rec chain cancel expData expExc
// Hex words; chain 1 issues with no idle cycle, cancel 1 expects no writeback
0 01 00000005 02 00000007 10 00 0 00 00000000 0 0 0 0000000c 0
0 01 7fffffff 02 00000001 11 01 0 00 00000000 0 0 0 80000000 1
1 01 00000010 02 00000003 12 02 0 00 00000000 0 0 0 0000000d 0
1 01 80000000 02 00000001 13 03 0 00 00000000 0 0 0 7fffffff 1
2 01 f0f0f0f0 02 0ff00ff0 14 04 0 00 00000000 0 0 0 00f000f0 0
3 01 f0f0f0f0 02 0ff00ff0 15 05 0 00 00000000 0 0 0 fff0fff0 0
4 01 f0f0f0f0 02 0ff00ff0 16 06 0 00 00000000 0 0 0 ff00ff00 0
5 01 ffffffff 02 00000001 17 07 0 00 00000000 0 0 0 00000001 0
5 01 00000005 02 fffffffe 18 08 0 00 00000000 0 0 0 00000000 0
6 01 00000003 02 00000024 19 09 0 00 00000000 0 0 0 00000030 0
7 01 80000000 02 0000001f 1a 0a 0 00 00000000 0 0 0 00000001 0
8 03 00012345 04 00001000 1b 0b 0 00 00000000 0 0 0 12345000 0
9 03 ffffffff 04 ffffffff 1c 0c 0 00 00000000 0 1 0 fffffffe 0
a 03 00000064 04 00000007 1d 0d 0 00 00000000 0 1 0 0000000e 0
a 03 00001234 04 00000000 1e 0e 0 00 00000000 0 1 0 ffffffff 1
0 01 00000001 02 00000002 20 0f 0 00 00000000 0 0 0 00000003 0
0 20 00000000 03 00000010 21 10 0 00 00000000 0 1 0 00000013 0
0 21 00000000 05 00000001 22 11 1 21 00000100 0 1 0 00000101 0
0 00 00000000 00 00000004 00 12 1 00 deadbeef 0 1 0 00000004 0
0 00 00000000 06 00000009 23 13 0 00 00000000 0 1 0 00000009 0
8 03 00000003 04 00000005 24 14 0 00 00000000 0 0 1 0000000f 0
a 03 00000010 04 00000002 25 15 0 00 00000000 0 1 1 00000008 0
9 03 00000002 04 00000003 26 16 0 00 00000000 1 1 1 00000000 0
0 01 00000020 02 00000022 27 17 0 00 00000000 0 0 0 00000042 0
8 03 00000006 04 00000007 28 18 0 00 00000000 0 0 0 0000002a 0
1 01 00000001 02 00000002 29 19 0 00 00000000 0 0 0 ffffffff 0

// File: files.f
+incdir+hdl
hdl/exePkg.sv
hdl/exeIf.sv
hdl/OperandSelect.sv
hdl/SimpleAlu.sv
hdl/ComplexAlu.sv
hdl/WritebackSelect.sv
hdl/ExecuteLane.sv
verif/ClockGen.sv
verif/ExecuteLane_tb.sv
